// ==== lsu_macros.svh ====
// Timer window bounds, store buffer depth and address width
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Width of every byte address in the unit
`define ADDR_WIDTH 32

// Memory-mapped cycle timer, low word at 0x100 and high word at 0x104
`define TIMER_START 32'h0000_0100
`define TIMER_END   32'h0000_0107

// Number of store buffer entries, kept a power of two so the pointers wrap
`define STB_DEPTH 4

`endif

// ==== lsu_pkg.sv ====
// Shared LSU types: data word union, load operation, address and store entry
`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

    // ----------------------------------------------------------------------
    // Data and address types
    // ----------------------------------------------------------------------

    // One 32-bit word that can be read whole, as halves or as bytes
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] word16;
        logic [3:0][7:0]  word8;
    } data_word_t;

    // Byte address on every bus of the unit
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // ----------------------------------------------------------------------
    // Load operation
    // ----------------------------------------------------------------------

    // Access size of a load, byte, half word or word
    typedef enum logic [1:0] {
        LDB,
        LDH,
        LDW
    } ldu_size_t;

    // Size plus the flag that selects sign extension of sub-word results
    typedef struct packed {
        ldu_size_t size;
        logic      signed_load;
    } ldu_op_t;

    // One pending store, always a full word
    typedef struct packed {
        addr_t      addr;
        data_word_t data;
    } stb_entry_t;

endpackage : lsu_pkg

`default_nettype wire

// ==== wb_bus_if.sv ====
// Wishbone classic request/response bundle with master and slave modports
`default_nettype none
`timescale 1ns/1ps

interface wb_bus_if;
    import lsu_pkg::*;

    // Request side, owned by the master
    logic       cyc;
    logic       stb;
    logic       we;
    addr_t      adr;
    data_word_t dat_w;

    // Response side, owned by the slave
    data_word_t dat_r;
    logic       ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface : wb_bus_if

`default_nettype wire

// ==== mtimer.sv ====
// Free-running 64-bit cycle counter exposed as two read-only data words
`default_nettype none
`timescale 1ns/1ps

module mtimer (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // Index 0 is the low word, index 1 the high word
    output lsu_pkg::data_word_t timer_o [2]
);

    logic [63:0] count_q;

    // Counts every clock from zero after reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 64'd1;
        end
    end

    // The low half sits at the window base, the high half four bytes above
    assign timer_o[0].word = count_q[31:0];
    assign timer_o[1].word = count_q[63:32];

endmodule : mtimer

`default_nettype wire

// ==== store_buffer.sv ====
// Store FIFO with youngest-entry forward search and Wishbone write drain
`default_nettype none
`timescale 1ns/1ps

`include "lsu_macros.svh"

module store_buffer (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                store_valid_i,
    input  lsu_pkg::addr_t      store_addr_i,
    input  lsu_pkg::data_word_t store_data_i,
    output logic                store_ready_o,
    input  lsu_pkg::addr_t      fwd_addr_i,
    output logic                fwd_match_o,
    output lsu_pkg::data_word_t fwd_data_o,
    output logic                buffer_empty_o,
    wb_bus_if.master            bus
);
    import lsu_pkg::*;

    localparam int PTR_W = $clog2(`STB_DEPTH);
    localparam int CNT_W = $clog2(`STB_DEPTH + 1);

    stb_entry_t        entries [`STB_DEPTH];
    logic [PTR_W-1:0]  head_q;
    logic [PTR_W-1:0]  tail_q;
    logic [CNT_W-1:0]  count_q;
    logic [CNT_W-1:0]  count_next;
    logic              ready_q;
    logic              drain_q;
    logic              push;
    logic              pop;

    // ----------------------------------------------------------------------
    // FIFO bookkeeping
    // ----------------------------------------------------------------------

    assign push       = store_valid_i && ready_q;
    assign pop        = drain_q && bus.ack;
    assign count_next = count_q + CNT_W'(push) - CNT_W'(pop);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            ready_q <= 1'b0;
            drain_q <= 1'b0;
        end else begin
            if (push) begin
                tail_q <= tail_q + PTR_W'(1);
            end
            if (pop) begin
                head_q <= head_q + PTR_W'(1);
            end
            count_q <= count_next;
            // Ready follows the next occupancy so it is low exactly while full
            ready_q <= (count_next != CNT_W'(`STB_DEPTH));
            // A write ends on its ack, and the next head waits one cycle to start
            if (drain_q) begin
                drain_q <= !bus.ack;
            end else begin
                drain_q <= (count_q != '0);
            end
        end
    end

    // Entry storage carries payload only
    always_ff @(posedge clk_i) begin
        if (push) begin
            entries[tail_q] <= '{addr: store_addr_i, data: store_data_i};
        end
    end

    assign store_ready_o  = ready_q;
    assign buffer_empty_o = (count_q == '0);

    // ----------------------------------------------------------------------
    // Forward search, oldest to youngest so the newest match wins
    // ----------------------------------------------------------------------

    always_comb begin : forward_search
        logic [PTR_W-1:0] idx;
        fwd_match_o = 1'b0;
        fwd_data_o  = '0;
        for (int i = 0; i < `STB_DEPTH; i++) begin
            idx = head_q + PTR_W'(i);
            // Stores are whole words, so only the word address is compared
            if (CNT_W'(i) < count_q &&
                entries[idx].addr[`ADDR_WIDTH-1:2] == fwd_addr_i[`ADDR_WIDTH-1:2]) begin
                fwd_match_o = 1'b1;
                fwd_data_o  = entries[idx].data;
            end
        end
    end

    // The head entry is presented as a write for as long as the drain runs
    assign bus.cyc   = drain_q;
    assign bus.stb   = drain_q;
    assign bus.we    = 1'b1;
    assign bus.adr   = entries[head_q].addr;
    assign bus.dat_w = entries[head_q].data;

endmodule : store_buffer

`default_nettype wire

// ==== load_unit.sv ====
// Load FSM with timer, forward and bus sources and sub-word slicing
`default_nettype none
`timescale 1ns/1ps

`include "lsu_macros.svh"

module load_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                load_valid_i,
    input  lsu_pkg::addr_t      load_addr_i,
    input  lsu_pkg::ldu_op_t    load_op_i,
    input  lsu_pkg::data_word_t timer_i [2],
    output lsu_pkg::addr_t      fwd_addr_o,
    input  logic                fwd_match_i,
    input  lsu_pkg::data_word_t fwd_data_i,
    input  logic                buffer_empty_i,
    output lsu_pkg::data_word_t load_data_o,
    output logic                load_valid_o,
    output logic                load_idle_o,
    wb_bus_if.master            bus
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_BUFFER,
        WAIT_BUS,
        RESPOND
    } state_t;

    state_t     state_q;
    state_t     state_d;
    ldu_op_t    op_q;
    addr_t      addr_q;
    data_word_t data_q;
    data_word_t data_d;
    data_word_t sliced;
    logic       timer_hit;

    // ----------------------------------------------------------------------
    // Issue and source select
    // ----------------------------------------------------------------------

    // Decoded on the incoming address so a hit answers in one cycle
    assign timer_hit  = (load_addr_i >= `TIMER_START) && (load_addr_i <= `TIMER_END);
    // The store buffer is searched with the address being issued
    assign fwd_addr_o = load_addr_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Operation, address and the captured word are payload
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && load_valid_i) begin
            op_q   <= load_op_i;
            addr_q <= load_addr_i;
        end
        data_q <= data_d;
    end

    always_comb begin : next_state
        state_d = state_q;
        data_d  = data_q;
        case (state_q)
            IDLE: begin
                if (load_valid_i) begin
                    if (timer_hit) begin
                        // Address bit 2 picks the low or high timer word
                        data_d  = timer_i[load_addr_i[2]];
                        state_d = RESPOND;
                    end else if (load_op_i.size == LDW && fwd_match_i) begin
                        data_d  = fwd_data_i;
                        state_d = RESPOND;
                    end else if (load_op_i.size != LDW) begin
                        // Sub-word reads must see every older store in memory
                        state_d = WAIT_BUFFER;
                    end else begin
                        state_d = WAIT_BUS;
                    end
                end
            end
            WAIT_BUFFER: begin
                if (buffer_empty_i) begin
                    state_d = WAIT_BUS;
                end
            end
            WAIT_BUS: begin
                // Request stays up until the arbiter routes the ack here
                if (bus.ack) begin
                    data_d  = bus.dat_r;
                    state_d = RESPOND;
                end
            end
            RESPOND: begin
                state_d = IDLE;
            end
        endcase
    end

    // Word-aligned read while waiting on the bus
    assign bus.cyc   = (state_q == WAIT_BUS);
    assign bus.stb   = (state_q == WAIT_BUS);
    assign bus.we    = 1'b0;
    assign bus.adr   = {addr_q[`ADDR_WIDTH-1:2], 2'b00};
    assign bus.dat_w = '0;

    // ----------------------------------------------------------------------
    // Response slicing
    // ----------------------------------------------------------------------

    always_comb begin : slice_logic
        logic [7:0]  byte_v;
        logic [15:0] half_v;
        byte_v = data_q.word8[addr_q[1:0]];
        half_v = data_q.word16[addr_q[1]];
        case (op_q.size)
            LDB: sliced.word = {{24{op_q.signed_load & byte_v[7]}}, byte_v};
            LDH: sliced.word = {{16{op_q.signed_load & half_v[15]}}, half_v};
            // Word loads pass through unchanged
            default: sliced = data_q;
        endcase
    end

    assign load_data_o  = sliced;
    assign load_valid_o = (state_q == RESPOND);
    assign load_idle_o  = (state_q == IDLE);

endmodule : load_unit

`default_nettype wire

// ==== lsu_bus_arbiter.sv ====
// Two-master Wishbone classic arbiter with load priority and grant lock
`default_nettype none
`timescale 1ns/1ps

module lsu_bus_arbiter (
    input  logic     clk_i,
    input  logic     rst_n_i,
    wb_bus_if.slave  load_bus,
    wb_bus_if.slave  store_bus,
    wb_bus_if.master ext_bus
);

    logic locked_q;
    logic grant_store_q;
    logic sel_store;

    // A free bus goes to the load path first, a locked one keeps its owner
    always_comb begin
        if (locked_q) begin
            sel_store = grant_store_q;
        end else begin
            sel_store = !load_bus.cyc && store_bus.cyc;
        end
    end

    // Lock holds for every open cycle that has not been acked yet
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            locked_q      <= 1'b0;
            grant_store_q <= 1'b0;
        end else begin
            locked_q      <= ext_bus.cyc && !ext_bus.ack;
            grant_store_q <= sel_store;
        end
    end

    // Granted master passes straight through with no added cycle
    assign ext_bus.cyc   = sel_store ? store_bus.cyc   : load_bus.cyc;
    assign ext_bus.stb   = sel_store ? store_bus.stb   : load_bus.stb;
    assign ext_bus.we    = sel_store ? store_bus.we    : load_bus.we;
    assign ext_bus.adr   = sel_store ? store_bus.adr   : load_bus.adr;
    assign ext_bus.dat_w = sel_store ? store_bus.dat_w : load_bus.dat_w;

    // Read data is shared, ack only reaches the owner
    assign load_bus.dat_r  = ext_bus.dat_r;
    assign store_bus.dat_r = ext_bus.dat_r;
    assign load_bus.ack    = ext_bus.ack && !sel_store;
    assign store_bus.ack   = ext_bus.ack && sel_store;

endmodule : lsu_bus_arbiter

`default_nettype wire

// ==== lsu_top.sv ====
// LSU top level joining timer, store buffer, load FSM and bus arbiter
`default_nettype none
`timescale 1ns/1ps

module lsu_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // Load request and result
    input  logic                load_valid_i,
    input  lsu_pkg::addr_t      load_addr_i,
    input  lsu_pkg::ldu_op_t    load_op_i,
    output logic                load_idle_o,
    output logic                load_valid_o,
    output lsu_pkg::data_word_t load_data_o,
    // Store request
    input  logic                store_valid_i,
    input  lsu_pkg::addr_t      store_addr_i,
    input  lsu_pkg::data_word_t store_data_i,
    output logic                store_ready_o,
    // External Wishbone classic master
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output lsu_pkg::addr_t      wb_adr_o,
    output lsu_pkg::data_word_t wb_dat_o,
    input  lsu_pkg::data_word_t wb_dat_i,
    input  logic                wb_ack_i
);
    import lsu_pkg::*;

    data_word_t timer_data [2];
    addr_t      fwd_addr;
    logic       fwd_match;
    data_word_t fwd_data;
    logic       buffer_empty;

    wb_bus_if load_bus ();
    wb_bus_if store_bus ();
    wb_bus_if ext_bus ();

    mtimer u_mtimer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .timer_o (timer_data)
    );

    store_buffer u_store_buffer (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .store_valid_i  (store_valid_i),
        .store_addr_i   (store_addr_i),
        .store_data_i   (store_data_i),
        .store_ready_o  (store_ready_o),
        .fwd_addr_i     (fwd_addr),
        .fwd_match_o    (fwd_match),
        .fwd_data_o     (fwd_data),
        .buffer_empty_o (buffer_empty),
        .bus            (store_bus)
    );

    load_unit u_load_unit (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .load_valid_i   (load_valid_i),
        .load_addr_i    (load_addr_i),
        .load_op_i      (load_op_i),
        .timer_i        (timer_data),
        .fwd_addr_o     (fwd_addr),
        .fwd_match_i    (fwd_match),
        .fwd_data_i     (fwd_data),
        .buffer_empty_i (buffer_empty),
        .load_data_o    (load_data_o),
        .load_valid_o   (load_valid_o),
        .load_idle_o    (load_idle_o),
        .bus            (load_bus)
    );

    lsu_bus_arbiter u_arbiter (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .load_bus  (load_bus),
        .store_bus (store_bus),
        .ext_bus   (ext_bus)
    );

    // External bus onto plain ports
    assign wb_cyc_o      = ext_bus.cyc;
    assign wb_stb_o      = ext_bus.stb;
    assign wb_we_o       = ext_bus.we;
    assign wb_adr_o      = ext_bus.adr;
    assign wb_dat_o      = ext_bus.dat_w;
    assign ext_bus.dat_r = wb_dat_i;
    assign ext_bus.ack   = wb_ack_i;

endmodule : lsu_top

`default_nettype wire

// ==== tb_lsu_top.sv ====
// Directed testbench for lsu_top with a Wishbone memory model, compare tasks and a watchdog
`default_nettype none
`timescale 1ns/1ps

`include "lsu_macros.svh"

module tb_lsu_top;
    import lsu_pkg::*;

    logic        clk_i;
    logic        rst_n_i;
    logic        load_valid_i;
    addr_t       load_addr_i;
    ldu_op_t     load_op_i;
    logic        load_idle_o;
    logic        load_valid_o;
    data_word_t  load_data_o;
    logic        store_valid_i;
    addr_t       store_addr_i;
    data_word_t  store_data_i;
    logic        store_ready_o;
    logic        wb_cyc_o;
    logic        wb_stb_o;
    logic        wb_we_o;
    addr_t       wb_adr_o;
    data_word_t  wb_dat_o;
    data_word_t  wb_dat_i;
    logic        wb_ack_i;

    // Memory model contents and what it has seen on the bus
    data_word_t  mem [256];
    stb_entry_t  writes_seen [$];
    int          reads_started;
    int          writes_at_read;
    int          ready_low_cycles = 0;
    logic        slow_ack;
    logic [31:0] data_seed;
    int          check_errors;
    int          tests_passed;
    int          tests_failed;

    lsu_top dut (.*);

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    // ----------------------------------------------------------------------
    // Helper functions
    // ----------------------------------------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Every word of the model differs and depends on all index bits
    function automatic data_word_t fill_word(input int idx);
        data_word_t w;
        w.word = (32'(idx) * 32'h0107_0b13) ^ 32'h8e3c_5af1;
        return w;
    endfunction

    // Shifts the addressed lane down and then zero or sign extends it
    function automatic data_word_t slice_expected(input data_word_t w, input logic [1:0] off,
                                                  input ldu_size_t size, input logic sgn);
        logic [31:0] shifted;
        data_word_t  r;
        shifted = w.word >> {off, 3'b000};
        case (size)
            LDB: r.word = sgn ? {{24{shifted[7]}}, shifted[7:0]} : {24'h0, shifted[7:0]};
            LDH: r.word = sgn ? {{16{shifted[15]}}, shifted[15:0]} : {16'h0, shifted[15:0]};
            default: r.word = w.word;
        endcase
        return r;
    endfunction

    // ----------------------------------------------------------------------
    // Wishbone memory model
    // ----------------------------------------------------------------------

    initial begin : memory_model
        logic [31:0] delay_seed;
        int          wait_left;
        logic        busy;
        delay_seed     = 32'hde4f;
        wait_left      = 0;
        busy           = 1'b0;
        reads_started  = 0;
        writes_at_read = 0;
        wb_ack_i       = 1'b0;
        wb_dat_i       = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        forever begin
            @(posedge clk_i);
            #1;
            if (wb_ack_i) begin
                // The acked request ended at this edge
                wb_ack_i = 1'b0;
            end else if (wb_cyc_o && wb_stb_o) begin
                if (!busy) begin
                    busy       = 1'b1;
                    delay_seed = lcg_next(delay_seed);
                    // Slow mode pins the delay to the top of the 1 to 4 range
                    wait_left  = slow_ack ? 4 : 1 + int'(delay_seed[17:16]);
                    if (!wb_we_o) begin
                        reads_started++;
                        writes_at_read = writes_seen.size();
                    end
                end
                wait_left--;
                if (wait_left == 0) begin
                    busy = 1'b0;
                    if (wb_we_o) begin
                        mem[wb_adr_o[9:2]] = wb_dat_o;
                        writes_seen.push_back('{addr: wb_adr_o, data: wb_dat_o});
                    end else begin
                        wb_dat_i = mem[wb_adr_o[9:2]];
                    end
                    wb_ack_i = 1'b1;
                end
            end
        end
    end

    // Counts cycles in which the store buffer refused new stores
    always @(negedge clk_i) begin
        if (rst_n_i && !store_ready_o) begin
            ready_low_cycles++;
        end
    end

    // The whole sequence takes about 400 cycles even with every ack at its slowest
    initial begin : watchdog
        repeat (2000) @(posedge clk_i);
        $display("Watchdog expired: the tests did not complete within 2000 cycles");
        $display("Testbench failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Compare tasks and drivers
    // ----------------------------------------------------------------------

    task automatic compare_word(input string name, input data_word_t exp, input data_word_t act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp.word, act.word);
            check_errors++;
        end
    endtask

    task automatic compare_store(input string name, input stb_entry_t exp, input stb_entry_t act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h/%h, actual %h/%h", name,
                     exp.addr, exp.data.word, act.addr, act.data.word);
            check_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic ok, input string what);
        if (!ok) begin
            $display("ERROR %s: %s", name, what);
            check_errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        if (check_errors == errs_at_start) begin
            tests_passed++;
            $display("test %-16s : ok", name);
        end else begin
            tests_failed++;
            $display("test %-16s : %0d error(s)", name, check_errors - errs_at_start);
        end
    endtask

    // Issues one load and counts sampled cycles from acceptance to the result pulse
    task automatic issue_load(input string name, input addr_t addr, input ldu_size_t size,
                              input logic sgn, output data_word_t data, output int cycles);
        logic idle_error;
        idle_error = 1'b0;
        while (!load_idle_o) begin
            @(posedge clk_i);
            #1;
        end
        load_valid_i          = 1'b1;
        load_addr_i           = addr;
        load_op_i.size        = size;
        load_op_i.signed_load = sgn;
        @(posedge clk_i);
        #1;
        load_valid_i = 1'b0;
        cycles       = 1;
        while (!load_valid_o) begin
            if (load_idle_o && !idle_error) begin
                idle_error = 1'b1;
                check_flag(name, 1'b0, "load_idle_o rose before the load result");
            end
            @(posedge clk_i);
            #1;
            cycles++;
        end
        data = load_data_o;
    endtask

    task automatic push_store(input addr_t addr, input data_word_t data);
        store_valid_i = 1'b1;
        store_addr_i  = addr;
        store_data_i  = data;
        while (!store_ready_o) begin
            @(posedge clk_i);
            #1;
        end
        @(posedge clk_i);
        #1;
        store_valid_i = 1'b0;
    endtask

    task automatic wait_writes(input int n);
        while (writes_seen.size() < n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------

    task automatic test_timer();
        data_word_t t1;
        data_word_t t2;
        data_word_t got;
        int         cycles;
        int         errs;
        errs = check_errors;
        issue_load("timer", `TIMER_START, LDW, 1'b0, t1, cycles);
        check_flag("timer", cycles == 1, "first timer read was not answered in one cycle");
        issue_load("timer", `TIMER_START, LDW, 1'b0, t2, cycles);
        check_flag("timer", cycles == 1, "second timer read was not answered in one cycle");
        check_flag("timer", t2.word > t1.word, "timer did not advance between reads");
        // High word is still zero this early
        issue_load("timer", `TIMER_START + 32'd4, LDB, 1'b0, got, cycles);
        compare_word("timer", '0, got);
        finish_test("timer", errs);
    endtask

    task automatic test_word_load();
        addr_t      addrs [3];
        data_word_t got;
        int         cycles;
        int         errs;
        errs  = check_errors;
        addrs = '{32'h0000_0010, 32'h0000_00a4, 32'h0000_03fc};
        for (int i = 0; i < 3; i++) begin
            issue_load("word_load", addrs[i], LDW, 1'b0, got, cycles);
            compare_word("word_load", mem[addrs[i][9:2]], got);
        end
        finish_test("word_load", errs);
    endtask

    task automatic test_subword();
        addr_t      addr;
        data_word_t got;
        data_word_t sd;
        int         cycles;
        int         base;
        int         errs;
        errs = check_errors;
        // Each byte offset is read unsigned and then signed
        for (int k = 0; k < 8; k++) begin
            addr = 32'h0000_00c0 | addr_t'(k / 2);
            issue_load("subword", addr, LDB, k[0], got, cycles);
            compare_word("subword", slice_expected(mem[addr[9:2]], addr[1:0], LDB, k[0]), got);
        end
        for (int k = 0; k < 4; k++) begin
            addr = 32'h0000_00d0 | addr_t'(2 * (k / 2));
            issue_load("subword", addr, LDH, k[0], got, cycles);
            compare_word("subword", slice_expected(mem[addr[9:2]], addr[1:0], LDH, k[0]), got);
        end
        // A byte load behind two pending stores must wait until both are written
        base    = writes_seen.size();
        sd.word = 32'hf0e1_d2c3;
        push_store(32'h0000_0200, sd);
        push_store(32'h0000_0204, fill_word(7));
        issue_load("subword", 32'h0000_0203, LDB, 1'b1, got, cycles);
        compare_word("subword", slice_expected(sd, 2'd3, LDB, 1'b1), got);
        check_flag("subword", writes_at_read >= base + 2,
                   "byte load read the bus before the older stores were written");
        finish_test("subword", errs);
    endtask

    task automatic test_store_drain();
        stb_entry_t exp_w [4];
        int         base;
        int         low_start;
        int         errs;
        errs      = check_errors;
        base      = writes_seen.size();
        low_start = ready_low_cycles;
        slow_ack  = 1'b1;
        for (int i = 0; i < 4; i++) begin
            data_seed       = lcg_next(data_seed);
            exp_w[i].addr   = 32'h0000_0300 + addr_t'(16 * i);
            exp_w[i].data   = data_seed;
            push_store(exp_w[i].addr, exp_w[i].data);
        end
        wait_writes(base + 4);
        slow_ack = 1'b0;
        for (int i = 0; i < 4; i++) begin
            compare_store("store_drain", exp_w[i], writes_seen[base + i]);
        end
        check_flag("store_drain", ready_low_cycles > low_start,
                   "store_ready_o never fell while the buffer was full");
        finish_test("store_drain", errs);
    endtask

    task automatic test_forwarding();
        data_word_t d1;
        data_word_t d2;
        data_word_t d3;
        data_word_t got;
        int         cycles;
        int         base;
        int         reads_base;
        int         errs;
        errs       = check_errors;
        base       = writes_seen.size();
        reads_base = reads_started;
        slow_ack   = 1'b1;
        d1         = fill_word(101);
        d2         = fill_word(102);
        d3         = fill_word(103);
        push_store(32'h0000_0140, d1);
        issue_load("forwarding", 32'h0000_0140, LDW, 1'b0, got, cycles);
        compare_word("forwarding", d1, got);
        check_flag("forwarding", cycles == 1, "forwarded load took more than one cycle");
        // The newer store to the same word must hide the older one
        push_store(32'h0000_0150, d2);
        push_store(32'h0000_0150, d3);
        issue_load("forwarding", 32'h0000_0150, LDW, 1'b0, got, cycles);
        compare_word("forwarding", d3, got);
        check_flag("forwarding", cycles == 1, "forwarded load took more than one cycle");
        check_flag("forwarding", reads_started == reads_base,
                   "a forwarded load started a read on the bus");
        wait_writes(base + 3);
        slow_ack = 1'b0;
        finish_test("forwarding", errs);
    endtask

    task automatic test_load_priority();
        data_word_t got;
        data_word_t d;
        int         cycles;
        int         base;
        int         errs;
        errs     = check_errors;
        base     = writes_seen.size();
        slow_ack = 1'b1;
        for (int i = 0; i < 3; i++) begin
            data_seed = lcg_next(data_seed);
            d.word    = data_seed;
            push_store(32'h0000_0380 + addr_t'(4 * i), d);
        end
        // The load is issued right after the first write's ack and meets the next write
        do begin
            @(posedge clk_i);
        end while (!wb_ack_i);
        #1;
        issue_load("load_priority", 32'h0000_03c0, LDW, 1'b0, got, cycles);
        compare_word("load_priority", mem[8'hf0], got);
        // Both paths ask for the free bus in the same cycle and the read must win
        check_flag("load_priority", writes_at_read == base + 1,
                   "the read was not granted ahead of the next queued write");
        wait_writes(base + 3);
        slow_ack = 1'b0;
        finish_test("load_priority", errs);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin : main
        rst_n_i       = 1'b0;
        load_valid_i  = 1'b0;
        load_addr_i   = '0;
        load_op_i     = '0;
        store_valid_i = 1'b0;
        store_addr_i  = '0;
        store_data_i  = '0;
        slow_ack      = 1'b0;
        data_seed     = 32'hde4f;
        check_errors  = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        @(posedge clk_i);
        #1;
        test_timer();
        test_word_load();
        test_subword();
        test_store_drain();
        test_forwarding();
        test_load_priority();
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_lsu_top

`default_nettype wire

// ==== list.f ====
+incdir+.
lsu_pkg.sv
wb_bus_if.sv
mtimer.sv
store_buffer.sv
load_unit.sv
lsu_bus_arbiter.sv
lsu_top.sv
tb_lsu_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_lsu_top -f list.f -o tb_lsu_top
./obj_dir/tb_lsu_top > sim.log
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
